/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_zx_memory
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard design/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR)

/* design/bus_port.sv */
module bus_port import zx_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      req,
	input  cpu_addr_t addr,
	input  byte_t     wdata,
	input  logic      wr,
	input  logic      io,
	input  logic      download,
	input  logic      done,
	input  byte_t     done_data,
	output logic      ack,
	output byte_t     rdata,
	output logic      cap_valid,
	output cpu_addr_t cap_addr,
	output byte_t     cap_wdata,
	output logic      cap_wr,
	output logic      cap_io
);

	// Four-phase slave states
	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_acked,
		st_release
	} state_t;

	state_t state;
	logic   take;

	// Download owns the memory, hold off new cycles
	assign take = (state == st_idle) & req & ~download;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= st_idle;
			ack       <= 1'b0;
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= take;           // One cycle into the pipeline
			case (state)
				st_idle: if (take) state <= st_busy;
				st_busy: begin
					if (done) begin
						ack   <= 1'b1;
						state <= st_acked;
					end
				end
				st_acked: if (!req) state <= st_release;
				st_release: begin
					ack   <= 1'b0;        // Drop one cycle after req low
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Captured fields and returned data
	always_ff @(posedge clk_sys) begin
		if (take) begin
			cap_addr  <= addr;
			cap_wdata <= wdata;
			cap_wr    <= wr;
			cap_io    <= io;
		end
		if (done && state == st_busy) rdata <= done_data;
	end

endmodule

/* design/cycle_decode.sv */
module cycle_decode import zx_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  arch_t     arch_sel,
	input  logic      cap_valid,
	input  cpu_addr_t cap_addr,
	input  byte_t     cap_wdata,
	input  logic      cap_wr,
	input  logic      cap_io,
	output logic      dec_valid,
	output cpu_addr_t dec_addr,
	output byte_t     dec_wdata,
	output logic      dec_wr,
	output logic      dec_io,
	output arch_t     machine,
	output logic      sel_7ffd,
	output logic      sel_1ffd,
	output logic      sel_ula,
	output logic      sel_kempston
);

	logic is_plus3;
	logic hit_7ffd;
	logic hit_1ffd;
	logic hit_ula;
	logic hit_kempston;

	assign is_plus3 = (machine == arch_plus3);

	// ====================
	// Port decode
	// ====================

	// 7FFD needs A14 high on the +3, 1FFD shares the A1 low rule
	assign hit_7ffd     = ~cap_addr[15] & ~cap_addr[1] & (cap_addr[14] | ~is_plus3);
	assign hit_1ffd     = is_plus3 & (cap_addr[15:12] == 4'b0001) & ~cap_addr[1];
	assign hit_ula      = ~cap_addr[0];                   // Any even port
	assign hit_kempston = (cap_addr[5:0] == KEMPSTON_LOW);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine   <= arch_sel;  // Model follows the input while in reset
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= cap_valid;
		end
	end

	// Selects stay low for memory cycles
	always_ff @(posedge clk_sys) begin
		if (cap_valid) begin
			dec_addr     <= cap_addr;
			dec_wdata    <= cap_wdata;
			dec_wr       <= cap_wr;
			dec_io       <= cap_io;
			sel_7ffd     <= cap_io & hit_7ffd;
			sel_1ffd     <= cap_io & hit_1ffd;
			sel_ula      <= cap_io & hit_ula;
			sel_kempston <= cap_io & hit_kempston;
		end
	end

endmodule

/* design/mem_io_stage.sv */
module mem_io_stage import zx_pkg::*; #(
	parameter int MEM_WAIT = MEM_WAIT_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       map_valid,
	input  phys_addr_t phys_addr,
	input  logic       mem_rd,
	input  logic       mem_we,
	input  byte_t      map_wdata,
	input  logic       map_io,
	input  logic       map_wr,
	input  logic       map_ula,
	input  logic       map_kempston,
	input  logic       download,
	input  logic       dl_wr,
	input  phys_addr_t dl_addr,
	input  byte_t      dl_data,
	input  logic [5:0] joystick,
	input  logic [4:0] key_data,
	output logic       done,
	output byte_t      done_data,
	output logic [2:0] border,
	output logic       ear,
	output logic       mic
);

	localparam int WAIT_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

	byte_t             mem [MEM_PAGES * PAGE_SIZE];
	byte_t             mem_q;
	logic [WAIT_W-1:0] remain;
	logic [WAIT_W-1:0] cur_remain;
	logic              active;
	logic              pend_we;
	logic              cur_active;
	logic              cur_pend_we;
	logic              dl_we;
	logic              bus_we;
	phys_addr_t        wr_addr;
	byte_t             wr_data;

	// ====================
	// Memory array
	// ====================

	assign dl_we       = download & dl_wr & (dl_addr[17:OFFSET_W] < MEM_PAGES);
	assign cur_active  = map_valid | active;
	assign cur_remain  = map_valid ? WAIT_W'(MEM_WAIT) : remain;
	assign cur_pend_we = map_valid ? mem_we : pend_we;
	assign bus_we      = cur_active & cur_pend_we & ~dl_we;   // Download wins the port
	assign wr_addr     = dl_we ? dl_addr : phys_addr;
	assign wr_data     = dl_we ? dl_data : map_wdata;

	always_ff @(posedge clk_sys) begin
		if (dl_we || bus_we) mem[wr_addr] <= wr_data;
		mem_q <= mem[phys_addr];
	end

	// Wait counter, done waits for a held-off write too
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active  <= 1'b0;
			pend_we <= 1'b0;
			remain  <= '0;
			done    <= 1'b0;
			border  <= 3'd0;
			ear     <= 1'b0;
			mic     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (cur_active) begin
				if (cur_remain == '0 && !(cur_pend_we && !bus_we)) begin
					done    <= 1'b1;
					active  <= 1'b0;
					pend_we <= 1'b0;
				end else begin
					active  <= 1'b1;
					pend_we <= cur_pend_we & ~bus_we;
					remain  <= (cur_remain != '0) ? cur_remain - 1'b1 : '0;
				end
			end
			// ULA output latch
			if (map_valid && map_io && map_wr && map_ula) begin
				border <= map_wdata[2:0];
				mic    <= map_wdata[3];
				ear    <= map_wdata[4];
			end
		end
	end

	// Read data
	always_comb begin
		if (mem_rd) done_data = mem_q;
		else if (map_io && !map_wr && map_kempston) done_data = {2'b00, joystick};
		else if (map_io && !map_wr && map_ula) done_data = {1'b1, ear | mic, 1'b1, key_data};
		else done_data = 8'hFF;                          // Unused port or write
	end

endmodule

/* design/page_map.sv */
module page_map import zx_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  arch_t      machine,
	input  logic       dec_valid,
	input  cpu_addr_t  dec_addr,
	input  byte_t      dec_wdata,
	input  logic       dec_wr,
	input  logic       dec_io,
	input  logic       sel_7ffd,
	input  logic       sel_1ffd,
	input  logic       sel_ula,
	input  logic       sel_kempston,
	output logic       map_valid,
	output phys_addr_t phys_addr,
	output logic       mem_rd,
	output logic       mem_we,
	output byte_t      map_wdata,
	output logic       map_io,
	output logic       map_wr,
	output logic       map_ula,
	output logic       map_kempston
);

	byte_t      reg_7ffd;
	byte_t      reg_1ffd;
	logic       page_lock;
	logic       port_write;
	logic       special;
	logic [1:0] quarter;
	logic [1:0] rom_num;
	phys_page_t page;
	logic       is_rom;

	// +3 all-RAM layouts, indexed by 1FFD bits 2..1
	function automatic phys_page_t special_page(input logic [1:0] mode, input logic [1:0] q);
		bank_t bank;
		case (mode)
			2'd0: bank = {1'b0, q};                          // 0 1 2 3
			2'd1: bank = {1'b1, q};                          // 4 5 6 7
			2'd2: bank = (q == 2'd3) ? 3'd3 : {1'b1, q};     // 4 5 6 3
			default: begin                                   // 4 7 6 3
				if (q == 2'd3) bank = 3'd3;
				else if (q == 2'd1) bank = 3'd7;
				else bank = {1'b1, q};
			end
		endcase
		return {1'b0, bank};
	endfunction

	// ====================
	// Paging registers
	// ====================

	assign page_lock  = reg_7ffd[5] | (machine == arch_zx48);
	assign port_write = dec_valid & dec_io & dec_wr & ~page_lock;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd  <= '0;
			reg_1ffd  <= '0;
			map_valid <= 1'b0;
		end else begin
			map_valid <= dec_valid;
			if (port_write && sel_7ffd) reg_7ffd <= dec_wdata;
			if (port_write && sel_1ffd) reg_1ffd <= dec_wdata;
		end
	end

	// ====================
	// Address translation
	// ====================

	assign quarter = dec_addr[15:OFFSET_W];
	assign special = (machine == arch_plus3) & reg_1ffd[0];

	always_comb begin
		case (machine)
			arch_zx48:  rom_num = 2'd1;                       // Only the BASIC ROM
			arch_zx128: rom_num = {1'b0, reg_7ffd[4]};
			default:    rom_num = {reg_1ffd[2], reg_7ffd[4]};
		endcase
	end

	always_comb begin
		if (special) begin
			page = special_page(reg_1ffd[2:1], quarter);
		end else begin
			case (quarter)
				2'd0: page = ROM_BASE_PAGE | {2'b00, rom_num};
				2'd1: page = PAGE_SCREEN;
				2'd2: page = PAGE_MID;
				default: page = (machine == arch_zx48) ? 4'd0 : {1'b0, reg_7ffd[2:0]};
			endcase
		end
	end

	assign is_rom = (page >= ROM_BASE_PAGE);

	always_ff @(posedge clk_sys) begin
		if (dec_valid) begin
			phys_addr    <= {page, dec_addr[OFFSET_W-1:0]};
			mem_rd       <= ~dec_io & ~dec_wr;
			mem_we       <= ~dec_io & dec_wr & ~is_rom;  // ROM is read only from the bus
			map_wdata    <= dec_wdata;
			map_io       <= dec_io;
			map_wr       <= dec_wr;
			map_ula      <= sel_ula;
			map_kempston <= sel_kempston;
		end
	end

endmodule

/* design/zx_memory_top.sv */
module zx_memory_top import zx_pkg::*; #(
	parameter int MEM_WAIT = MEM_WAIT_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  arch_t      arch_sel,
	// CPU bus
	input  logic       req,
	input  cpu_addr_t  addr,
	input  byte_t      wdata,
	input  logic       wr,
	input  logic       io,
	output logic       ack,
	output byte_t      rdata,
	// Download port
	input  logic       download,
	input  logic       dl_wr,
	input  phys_addr_t dl_addr,
	input  byte_t      dl_data,
	// Inputs and ULA outputs
	input  logic [5:0] joystick,
	input  logic [4:0] key_data,
	output logic [2:0] border,
	output logic       ear,
	output logic       mic
);

	// ====================
	// Stage links
	// ====================

	logic       cap_valid, cap_wr, cap_io;
	cpu_addr_t  cap_addr;
	byte_t      cap_wdata;
	logic       dec_valid, dec_wr, dec_io;
	cpu_addr_t  dec_addr;
	byte_t      dec_wdata;
	arch_t      machine;
	logic       sel_7ffd, sel_1ffd, sel_ula, sel_kempston;
	logic       map_valid, mem_rd, mem_we, map_io, map_wr, map_ula, map_kempston;
	phys_addr_t phys_addr;
	byte_t      map_wdata;
	logic       done;
	byte_t      done_data;

	bus_port i_bus_port (.*);

	cycle_decode i_cycle_decode (.*);

	page_map i_page_map (.*);

	mem_io_stage #(
		.MEM_WAIT(MEM_WAIT)
	) i_mem_io_stage (.*);

endmodule

/* design/zx_pkg.sv */
package zx_pkg;

	// ====================
	// Bus widths
	// ====================

	// Z80 side address and data
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;

	// ====================
	// Physical memory map
	// ====================

	// Page in 17..14, offset in 13..0
	typedef logic [17:0] phys_addr_t;

	// 0..7 are RAM banks, 8..11 are ROMs 0..3
	typedef logic [3:0]  phys_page_t;

	// RAM bank number as written to 7FFD bits 2..0
	typedef logic [2:0]  bank_t;

	// Machine model, latched at reset
	typedef enum logic [1:0] {
		arch_zx48  = 2'd0,
		arch_zx128 = 2'd1,
		arch_plus3 = 2'd2
	} arch_t;

	localparam int OFFSET_W  = 14;             // 16K pages
	localparam int PAGE_SIZE = 1 << OFFSET_W;
	localparam int MEM_PAGES = 12;             // 8 RAM banks plus 4 ROMs

	// First ROM page, ROM n sits at ROM_BASE_PAGE + n
	localparam phys_page_t ROM_BASE_PAGE = 4'd8;

	// Fixed banks of the normal 128K layout
	localparam phys_page_t PAGE_SCREEN = 4'd5; // 4000..7FFF
	localparam phys_page_t PAGE_MID    = 4'd2; // 8000..BFFF

	// ====================
	// I/O decode
	// ====================

	// Kempston joystick, low six address bits
	localparam logic [5:0] KEMPSTON_LOW = 6'h1F;

	// Stand-in SDRAM latency
	localparam int MEM_WAIT_DEFAULT = 2;

endpackage

/* test/tb_tests.svh */
// ====================
// Bus and download drivers
// ====================

task automatic wait_ack(input logic level, input int limit, input string what);
	int n;
	n = 0;
	while (ack !== level && n < limit) begin
		@(negedge clk_sys);
		n++;
	end
	if (ack !== level) fail_run(what);
endtask

task automatic start_cycle(input cpu_addr_t a, input byte_t d, input logic is_wr,
	input logic is_io);
	@(negedge clk_sys);
	addr  = a;
	wdata = d;
	wr    = is_wr;
	io    = is_io;
	req   = 1'b1;
endtask

task automatic finish_cycle(output byte_t q);
	wait_ack(1'b1, ACK_LIMIT, "Bus cycle was never acknowledged");
	q   = rdata;
	req = 1'b0;                // Four-phase release
	wait_ack(1'b0, 4, "ack stayed high after req was released");
endtask

task automatic bus_cycle(input cpu_addr_t a, input byte_t d, input logic is_wr,
	input logic is_io, output byte_t q);
	start_cycle(a, d, is_wr, is_io);
	finish_cycle(q);
endtask

task automatic port_write(input cpu_addr_t a, input byte_t d);
	byte_t unused_q;
	bus_cycle(a, d, 1'b1, 1'b1, unused_q);
endtask

task automatic read_check(input cpu_addr_t a, input logic is_io, input byte_t expected,
	input string name);
	byte_t q;
	bus_cycle(a, 8'h00, 1'b0, is_io, q);
	check_value(name, expected, q);
endtask

// Leaves download high for the caller to drop
task automatic dl_write(input phys_addr_t pa, input byte_t d);
	@(negedge clk_sys);
	download = 1'b1;
	dl_wr    = 1'b1;
	dl_addr  = pa;
	dl_data  = d;
	@(negedge clk_sys);
	dl_wr = 1'b0;
endtask

task automatic load_markers();
	int p;
	int rnd;
	for (p = 0; p < MEM_PAGES; p++) begin
		rnd       = $random(seed);
		marker[p] = {4'(rnd), 4'(p)};   // Page number in low nibble keeps them distinct
		dl_write({4'(p), DATA_OFS}, marker[p]);
	end
	download = 1'b0;
endtask

// All four quarters against the reference layout
task automatic check_quarters(input arch_t m, input byte_t r7, input byte_t r1);
	int q;
	for (q = 0; q < 4; q++)
		read_check({2'(q), DATA_OFS}, 1'b0, marker[expected_page(m, r7, r1, q)], "rdata");
endtask

// ====================
// Directed tests
// ====================

task automatic paging_128k();
	int bank;
	apply_reset(arch_zx128);
	load_markers();
	for (bank = 0; bank < 8; bank++) begin
		port_write(16'h7FFD, 8'(bank));
		check_quarters(arch_zx128, 8'(bank), 8'h00);
	end
endtask

task automatic rom_select_protect();
	int    r;
	byte_t unused_q;
	load_markers();
	apply_reset(arch_zx48);
	check_quarters(arch_zx48, 8'h00, 8'h00);
	apply_reset(arch_zx128);
	for (r = 0; r < 2; r++) begin
		port_write(16'h7FFD, 8'(r << 4));
		check_quarters(arch_zx128, 8'(r << 4), 8'h00);
	end
	bus_cycle({2'd0, DATA_OFS}, ~marker[9], 1'b1, 1'b0, unused_q);   // ROM 1 is mapped
	read_check({2'd0, DATA_OFS}, 1'b0, marker[9], "rdata");
	apply_reset(arch_plus3);
	for (r = 0; r < 4; r++) begin
		port_write(16'h1FFD, 8'((r >> 1) << 2));
		port_write(16'h7FFD, 8'((r & 1) << 4));
		check_quarters(arch_plus3, 8'((r & 1) << 4), 8'((r >> 1) << 2));
	end
endtask

task automatic lock_and_48k();
	apply_reset(arch_zx128);
	port_write(16'h7FFD, 8'h23);                 // Bank 3 and lock
	check_quarters(arch_zx128, 8'h23, 8'h00);
	port_write(16'h7FFD, 8'h16);
	check_quarters(arch_zx128, 8'h23, 8'h00);    // Layout unchanged
	apply_reset(arch_zx48);
	port_write(16'h7FFD, 8'h07);
	check_quarters(arch_zx48, 8'h07, 8'h00);
endtask

task automatic plus3_special_modes();
	int m;
	apply_reset(arch_plus3);
	for (m = 0; m < 4; m++) begin
		port_write(16'h1FFD, 8'((m << 1) | 1));
		check_quarters(arch_plus3, 8'h00, 8'((m << 1) | 1));
	end
endtask

task automatic ula_and_inputs();
	int         rnd;
	byte_t      d;
	logic [5:0] joy;
	logic [4:0] keys;
	apply_reset(arch_zx128);
	check_value("ack", 8'h00, 8'(ack));
	check_value("border", 8'h00, 8'(border));
	check_value("mic", 8'h00, 8'(mic));
	check_value("ear", 8'h00, 8'(ear));
	rnd = $random(seed);
	d   = 8'(rnd);
	port_write(16'h00FE, d);
	check_value("border", 8'(d[2:0]), 8'(border));
	check_value("mic", 8'(d[3]), 8'(mic));
	check_value("ear", 8'(d[4]), 8'(ear));
	rnd  = $random(seed);
	joy  = 6'(rnd);
	keys = 5'(rnd >> 8);
	@(negedge clk_sys);
	joystick = joy;
	key_data = keys;
	read_check(16'h00FE, 1'b1, {1'b1, d[4] | d[3], 1'b1, keys}, "rdata");
	port_write(16'h00FE, 8'h08);                 // Mic alone sets bit 6
	read_check(16'h00FE, 1'b1, {3'b111, keys}, "rdata");
	read_check(16'h001F, 1'b1, {2'b00, joy}, "rdata");
	read_check(16'h00FF, 1'b1, 8'hFF, "rdata");   // Nothing decodes here
endtask

task automatic download_backpressure();
	int    n;
	byte_t fresh;
	byte_t q;
	apply_reset(arch_zx128);
	@(negedge clk_sys);
	download = 1'b1;
	start_cycle({2'd2, DATA_OFS}, 8'h00, 1'b0, 1'b0);
	for (n = 0; n < HOLD_CYCLES; n++) begin
		@(negedge clk_sys);
		check_value("ack", 8'h00, 8'(ack));
	end
	fresh = ~marker[2];
	dl_write({4'd2, DATA_OFS}, fresh);   // Bank 2 behind 8000
	marker[2] = fresh;
	check_value("ack", 8'h00, 8'(ack));
	download = 1'b0;
	finish_cycle(q);
	check_value("rdata", fresh, q);
endtask

/* test/tb_zx_memory.sv */
module tb_zx_memory import zx_pkg::*; ();

	// ====================
	// Run limits
	// ====================

	localparam int CLK_PERIOD    = 10;
	localparam int MEM_WAIT      = 3;
	localparam int ACK_LIMIT     = 4 + MEM_WAIT + 4;       // req to ack plus slack
	localparam int HOLD_CYCLES   = 12;                     // Back-pressure window
	localparam int NUM_TESTS     = 6;
	localparam int TEST_CYCLES   = 64 * (ACK_LIMIT + 4);   // Bus ops of the longest test times bound
	localparam int WATCHDOG_TIME = (NUM_TESTS * TEST_CYCLES + 100) * CLK_PERIOD;

	localparam logic [13:0] DATA_OFS = 14'h0155;         // Marker offset in every page

	logic       clk_sys;
	logic       reset;
	arch_t      arch_sel;
	logic       req;
	cpu_addr_t  addr;
	byte_t      wdata;
	logic       wr;
	logic       io;
	logic       ack;
	byte_t      rdata;
	logic       download;
	logic       dl_wr;
	phys_addr_t dl_addr;
	byte_t      dl_data;
	logic [5:0] joystick;
	logic [4:0] key_data;
	logic [2:0] border;
	logic       ear;
	logic       mic;

	int         seed;
	byte_t      marker [MEM_PAGES];   // Byte stored at DATA_OFS of each page

	zx_memory_top #(
		.MEM_WAIT(MEM_WAIT)
	) i_zx_memory_top (.*);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// Ends the run on any failure
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input byte_t expected, input byte_t actual);
		if (expected !== actual)
			fail_run($sformatf("MISMATCH at time %0t: %s expected %h actual %h",
				$time, name, expected, actual));
	endtask

	// Model latched while reset is high
	task automatic apply_reset(input arch_t a);
		@(negedge clk_sys);
		reset    = 1'b1;
		arch_sel = a;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// ====================
	// Reference paging rules
	// ====================

	function automatic int expected_page(input arch_t m, input byte_t r7, input byte_t r1,
		input int q);
		logic [15:0] layout;   // One nibble per quarter with quarter 0 lowest
		int          rom;
		if (m == arch_plus3 && r1[0]) begin
			case (r1[2:1])
				2'd0:    layout = 16'h3210;
				2'd1:    layout = 16'h7654;
				2'd2:    layout = 16'h3654;
				default: layout = 16'h3674;
			endcase
			return int'(layout[4*q +: 4]);
		end
		case (m)
			arch_zx48:  rom = 1;
			arch_zx128: rom = int'(r7[4]);
			default:    rom = 2 * int'(r1[2]) + int'(r7[4]);
		endcase
		case (q)
			0:       return int'(ROM_BASE_PAGE) + rom;
			1:       return 5;
			2:       return 2;
			default: return (m == arch_zx48) ? 0 : int'(r7[2:0]);
		endcase
	endfunction

	`include "tb_tests.svh"

	initial begin
		seed     = 32'h13bb_2e51;
		reset    = 1'b1;
		arch_sel = arch_zx128;
		req      = 1'b0;
		addr     = '0;
		wdata    = '0;
		wr       = 1'b0;
		io       = 1'b0;
		download = 1'b0;
		dl_wr    = 1'b0;
		dl_addr  = '0;
		dl_data  = '0;
		joystick = '0;
		key_data = '0;
		paging_128k();
		rom_select_protect();
		lock_and_48k();
		plus3_special_modes();
		ula_and_inputs();
		download_backpressure();
		$display("Finished with no errors");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		fail_run("Watchdog expired before all tests completed");
	end

endmodule

/* verilog.f */
+incdir+test
design/zx_pkg.sv
design/bus_port.sv
design/cycle_decode.sv
design/page_map.sv
design/mem_io_stage.sv
design/zx_memory_top.sv
test/tb_zx_memory.sv
